// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 8;
    localparam int REG_AW   = 3;
    localparam int IMM_W    = 16;

    // codes 11 to 15 are illegal
    typedef enum logic [3:0] {
        NOP   = 4'd0,
        ADD   = 4'd1,
        SUB   = 4'd2,
        AND   = 4'd3,
        OR    = 4'd4,
        XOR   = 4'd5,
        MOVI  = 4'd6,  // dst = zero-extended imm
        STORE = 4'd7,
        JMP   = 4'd8,
        JZ    = 4'd9,
        HALT  = 4'd10
    } op_e;

    typedef struct packed {
        logic [3:0]        opcode;
        logic [REG_AW-1:0] dst;
        logic [REG_AW-1:0] src1;
        logic [REG_AW-1:0] src2;
        logic [2:0]        unused;
        logic [IMM_W-1:0]  imm;
    } instr_t;

    typedef struct packed {
        logic zero;
        logic sign;
        logic carry;  // borrow after SUB
    } eflags_t;

    typedef enum logic [1:0] {
        IE_NONE,
        IE_ILLEGAL,
        IE_MISALIGNED
    } ie_e;

endpackage

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    localparam int STORE_QUEUE_DEPTH = 2;
    localparam int SQ_PTR_W          = $clog2(STORE_QUEUE_DEPTH);
    localparam int SQ_CNT_W          = $clog2(STORE_QUEUE_DEPTH + 1);

    // decode register contents
    typedef struct packed {
        op_e               opcode;
        logic [REG_AW-1:0] dst;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [IMM_W-1:0]  imm;
        logic [XLEN-1:0]   eip;
        logic              writes_reg;
        logic              illegal;
    } uop_t;

    typedef struct packed {
        op_e               opcode;
        logic [REG_AW-1:0] dst;
        logic [XLEN-1:0]   value;
        eflags_t           value_flags;
        logic              writes_reg;
        logic [XLEN-1:0]   st_addr;
        logic [XLEN-1:0]   st_data;
        logic [XLEN-1:0]   br_target;
        ie_e               ie_type;
        logic [XLEN-1:0]   eip;
    } exec_t;

    typedef struct packed {
        logic [XLEN-1:0]   eip;
        logic [REG_AW-1:0] dst;
        logic [XLEN-1:0]   value;
        logic              writes_reg;
        eflags_t           flags;  // architectural flags once this commits
    } retire_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } store_req_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_RESP
    } axil_state_e;

endpackage

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import isa_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [REG_AW-1:0] rd_addr_a,
    input  logic [REG_AW-1:0] rd_addr_b,
    output logic [XLEN-1:0]   rd_data_a,
    output logic [XLEN-1:0]   rd_data_b,
    input  logic              wr_en,
    input  logic [REG_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]   wr_data
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // no bypass, the decode scoreboard waits for the write
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  instr_t            in_instr,
    input  logic [XLEN-1:0]   in_eip,
    output logic              in_ready,
    output logic [REG_AW-1:0] rd_addr_a,
    output logic [REG_AW-1:0] rd_addr_b,
    input  logic [XLEN-1:0]   rd_data_a,
    input  logic [XLEN-1:0]   rd_data_b,
    input  logic [REG_AW-1:0] ex_dst,
    input  logic              ex_writes,
    input  logic [REG_AW-1:0] wb_dst,
    input  logic              wb_writes,
    input  logic              stall,
    input  logic              flush,
    input  logic              halted,
    output logic              uop_valid,
    output uop_t              uop
);

    op_e  op;
    logic writes;
    logic illegal;
    logic use_a;
    logic use_b;
    logic own_pend;
    logic hit_a;
    logic hit_b;
    logic started;  // one idle cycle after reset release
    logic xfer;

    assign op        = op_e'(in_instr.opcode);
    assign rd_addr_a = in_instr.src1;
    assign rd_addr_b = in_instr.src2;

    always_comb begin
        writes  = 1'b0;
        illegal = 1'b0;
        use_a   = 1'b0;
        use_b   = 1'b0;
        case (op)
            ADD, SUB, AND, OR, XOR: begin
                writes = 1'b1;
                use_a  = 1'b1;
                use_b  = 1'b1;
            end
            MOVI: writes = 1'b1;
            STORE: begin
                use_a = 1'b1;  // address base
                use_b = 1'b1;  // store data
            end
            NOP, JMP, JZ, HALT: begin
            end
            default: illegal = 1'b1;
        endcase
    end

    // pending destinations in decode, execute and writeback
    assign own_pend = uop_valid && uop.writes_reg;
    assign hit_a = use_a && ((own_pend && uop.dst == in_instr.src1) ||
                             (ex_writes && ex_dst == in_instr.src1) ||
                             (wb_writes && wb_dst == in_instr.src1));
    assign hit_b = use_b && ((own_pend && uop.dst == in_instr.src2) ||
                             (ex_writes && ex_dst == in_instr.src2) ||
                             (wb_writes && wb_dst == in_instr.src2));

    assign in_ready = started && !stall && !halted && !hit_a && !hit_b;
    assign xfer     = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started   <= 1'b0;
            uop_valid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (flush) begin
                uop_valid <= 1'b0;  // drops a same-cycle transfer too
            end else if (!stall) begin
                uop_valid <= xfer;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            uop <= '{opcode: op, dst: in_instr.dst, a: rd_data_a, b: rd_data_b,
                     imm: in_instr.imm, eip: in_eip, writes_reg: writes,
                     illegal: illegal};
        end
    end

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              uop_valid,
    input  uop_t              uop,
    input  logic              stall,
    input  logic              flush,
    output logic              ex_valid,
    output exec_t             ex,
    output logic [REG_AW-1:0] ex_dst,
    output logic              ex_writes
);

    exec_t           res;
    logic [XLEN:0]   sum;      // top bit is carry or borrow
    logic [XLEN-1:0] st_addr;

    assign st_addr = uop.a + {{(XLEN-IMM_W){uop.imm[IMM_W-1]}}, uop.imm};

    always_comb begin
        sum            = '0;
        res            = '0;  // carry stays clear for logic ops
        res.opcode     = uop.opcode;
        res.dst        = uop.dst;
        res.writes_reg = uop.writes_reg;
        res.eip        = uop.eip;
        res.ie_type    = IE_NONE;
        case (uop.opcode)
            ADD: begin
                sum                   = {1'b0, uop.a} + {1'b0, uop.b};
                res.value             = sum[XLEN-1:0];
                res.value_flags.carry = sum[XLEN];
            end
            SUB: begin
                sum                   = {1'b0, uop.a} - {1'b0, uop.b};
                res.value             = sum[XLEN-1:0];
                res.value_flags.carry = sum[XLEN];
            end
            AND:  res.value = uop.a & uop.b;
            OR:   res.value = uop.a | uop.b;
            XOR:  res.value = uop.a ^ uop.b;
            MOVI: res.value = XLEN'(uop.imm);
            STORE: begin
                res.st_addr = st_addr;
                res.st_data = uop.b;
                if (st_addr[1:0] != 2'b00) begin
                    res.ie_type = IE_MISALIGNED;
                end
            end
            JMP, JZ: res.br_target = XLEN'(uop.imm);  // absolute target
            default: begin
            end
        endcase
        res.value_flags.zero = (res.value == '0);
        res.value_flags.sign = res.value[XLEN-1];
        if (uop.illegal) begin
            res.ie_type = IE_ILLEGAL;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (!stall) begin
            ex_valid <= uop_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex <= res;
        end
    end

    assign ex_dst    = ex.dst;
    assign ex_writes = ex_valid && ex.writes_reg;

endmodule

`default_nettype wire

// File: writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              ex_valid,
    input  exec_t             ex,
    input  logic              store_full,
    output logic              stall,
    output logic              flush,
    output logic [REG_AW-1:0] wb_dst,
    output logic              wb_writes,
    output logic              rf_wr_en,
    output logic [REG_AW-1:0] rf_wr_addr,
    output logic [XLEN-1:0]   rf_wr_data,
    output logic              store_push,
    output store_req_t        store_req,
    output logic              retire_valid,
    output retire_t           retire,
    output logic              resteer,
    output logic [XLEN-1:0]   new_eip,
    output logic              ie_val,
    output ie_e               ie_type,
    output logic [XLEN-1:0]   ie_eip,
    output logic              halted
);

    exec_t   wb;
    logic    wb_valid;
    eflags_t flags_q;   // architectural flags
    logic    halted_q;
    logic    live;
    logic    exc;
    logic    is_store;
    logic    is_alu;
    logic    commit;
    logic    taken;

    // anything behind a halt is dead
    assign live     = wb_valid && !halted_q;
    assign exc      = live && (wb.ie_type != IE_NONE);
    assign is_store = (wb.opcode == STORE);
    assign is_alu   = wb.opcode inside {ADD, SUB, AND, OR, XOR};
    assign stall    = live && !exc && is_store && store_full;
    assign commit   = live && !exc && !stall;
    assign taken    = commit && ((wb.opcode == JMP) || (wb.opcode == JZ && flags_q.zero));
    assign flush    = taken || exc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            flags_q  <= '0;
            halted_q <= 1'b0;
        end else begin
            if (flush) begin
                wb_valid <= 1'b0;  // execute holds a younger, squashed op
            end else if (!stall) begin
                wb_valid <= ex_valid;
            end
            if (commit && is_alu) begin
                flags_q <= wb.value_flags;
            end
            if (commit && wb.opcode == HALT) begin
                halted_q <= 1'b1;  // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb <= ex;
        end
    end

    assign wb_dst     = wb.dst;
    assign wb_writes  = live && wb.writes_reg;
    assign rf_wr_en   = commit && wb.writes_reg;
    assign rf_wr_addr = wb.dst;
    assign rf_wr_data = wb.value;

    assign store_push = commit && is_store;
    assign store_req  = '{addr: wb.st_addr, data: wb.st_data};

    assign retire_valid = commit;
    assign retire = '{eip: wb.eip, dst: wb.dst, value: wb.value, writes_reg: wb.writes_reg,
                      flags: is_alu ? wb.value_flags : flags_q};

    assign resteer = taken;
    assign new_eip = wb.br_target;
    assign ie_val  = exc;
    assign ie_type = wb.ie_type;
    assign ie_eip  = wb.eip;
    assign halted  = halted_q;

endmodule

`default_nettype wire

// File: store_axil_master.sv
`timescale 1ns/1ps
`default_nettype none

module store_axil_master import isa_pkg::*, pipe_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              store_push,
    input  store_req_t        store_req,
    output logic              store_full,
    output logic              awvalid,
    input  logic              awready,
    output logic [XLEN-1:0]   awaddr,
    output logic              wvalid,
    input  logic              wready,
    output logic [XLEN-1:0]   wdata,
    output logic [XLEN/8-1:0] wstrb,
    input  logic              bvalid,
    output logic              bready
);

    store_req_t          queue [STORE_QUEUE_DEPTH];
    logic [SQ_PTR_W-1:0] wr_ptr;
    logic [SQ_PTR_W-1:0] rd_ptr;
    logic [SQ_CNT_W-1:0] count;
    axil_state_e         state;
    logic                aw_pend;
    logic                w_pend;
    logic                pop;

    assign store_full = (count == SQ_CNT_W'(STORE_QUEUE_DEPTH));
    assign pop        = (state == ST_RESP) && bvalid;  // head leaves once the response is in

    always_ff @(posedge clk) begin
        if (store_push) begin
            queue[wr_ptr] <= store_req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            state   <= ST_IDLE;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else begin
            if (store_push) begin
                wr_ptr <= (wr_ptr == SQ_PTR_W'(STORE_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == SQ_PTR_W'(STORE_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (store_push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !store_push) begin
                count <= count - 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (count != '0) begin
                        state   <= ST_SEND;
                        aw_pend <= 1'b1;
                        w_pend  <= 1'b1;
                    end
                end
                ST_SEND: begin
                    if (awready) aw_pend <= 1'b0;
                    if (wready) w_pend <= 1'b0;
                    // address and data may complete in either order
                    if ((!aw_pend || awready) && (!w_pend || wready)) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: if (bvalid) state <= ST_IDLE;  // response code ignored
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign awvalid = (state == ST_SEND) && aw_pend;
    assign wvalid  = (state == ST_SEND) && w_pend;
    assign awaddr  = queue[rd_ptr].addr;
    assign wdata   = queue[rd_ptr].data;
    assign wstrb   = '1;
    assign bready  = (state == ST_RESP);

endmodule

`default_nettype wire

// File: wb_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_core_top import isa_pkg::*, pipe_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  instr_t            in_instr,
    input  logic [XLEN-1:0]   in_eip,
    output logic              in_ready,
    output logic              awvalid,
    input  logic              awready,
    output logic [XLEN-1:0]   awaddr,
    output logic              wvalid,
    input  logic              wready,
    output logic [XLEN-1:0]   wdata,
    output logic [XLEN/8-1:0] wstrb,
    input  logic              bvalid,
    output logic              bready,
    output logic              retire_valid,
    output retire_t           retire,
    output logic              resteer,
    output logic [XLEN-1:0]   new_eip,
    output logic              ie_val,
    output ie_e               ie_type,
    output logic [XLEN-1:0]   ie_eip,
    output logic              halted
);

    logic [REG_AW-1:0] rd_addr_a;
    logic [REG_AW-1:0] rd_addr_b;
    logic [XLEN-1:0]   rd_data_a;
    logic [XLEN-1:0]   rd_data_b;
    logic              rf_wr_en;
    logic [REG_AW-1:0] rf_wr_addr;
    logic [XLEN-1:0]   rf_wr_data;
    logic              uop_valid;
    uop_t              uop;
    logic              ex_valid;
    exec_t             ex;
    logic [REG_AW-1:0] ex_dst;
    logic              ex_writes;
    logic [REG_AW-1:0] wb_dst;
    logic              wb_writes;
    logic              stall;      // store queue full
    logic              flush;      // resteer or exception
    logic              store_push;
    store_req_t        store_req;
    logic              store_full;

    // ports share names with the local nets except the write port
    reg_file u_reg_file (.*, .wr_en(rf_wr_en), .wr_addr(rf_wr_addr), .wr_data(rf_wr_data));

    decode_stage u_decode (.*);

    execute_stage u_execute (.*);

    writeback_stage u_writeback (.*);

    store_axil_master u_store_master (.*);

endmodule

`default_nettype wire

// File: wb_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module wb_core_asserts import isa_pkg::*; (
    input logic            clk,
    input logic            arst_n,
    input logic            in_ready,
    input logic            halted,
    input logic            awvalid,
    input logic            awready,
    input logic [XLEN-1:0] awaddr,
    input logic            wvalid,
    input logic            wready,
    input logic [XLEN-1:0] wdata,
    input logic            retire_valid,
    input logic            ie_val
);

    int assert_errors = 0;  // failed property count

    a_halt_blocks_input: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !in_ready) else begin
        assert_errors++;
        $error("in_ready high while halted");
    end

    // AXI valid stays up with stable payload until ready
    a_aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr)) else begin
        assert_errors++;
        $error("awvalid dropped early");
    end

    a_w_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wvalid && !wready |=> wvalid && $stable(wdata)) else begin
        assert_errors++;
        $error("wvalid dropped early");
    end

    a_retire_or_ie: assert property (@(posedge clk) disable iff (!arst_n)
        !(retire_valid && ie_val)) else begin
        assert_errors++;
        $error("retire and exception in the same cycle");
    end

endmodule

bind wb_core_top wb_core_asserts u_asserts (.*);

`default_nettype wire

// File: tb_wb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_core import isa_pkg::*, pipe_pkg::*; ();

    typedef struct packed {
        instr_t          instr;
        logic [XLEN-1:0] eip;
    } slot_t;

    typedef struct packed {
        ie_e             kind;
        logic [XLEN-1:0] eip;
    } ie_rec_t;

    logic clk = 1'b0;
    logic arst_n;
    logic in_valid;
    instr_t in_instr;
    logic [XLEN-1:0] in_eip;
    logic in_ready;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic [XLEN-1:0] awaddr, wdata;
    logic [XLEN/8-1:0] wstrb;
    logic retire_valid, resteer, ie_val, halted;
    retire_t retire;
    logic [XLEN-1:0] new_eip, ie_eip;
    ie_e ie_type;

    // reference model state
    logic [XLEN-1:0] m_regs [NUM_REGS];
    eflags_t m_flags;
    bit m_squash;   // younger ops die until the flush shows up
    bit m_halted;
    retire_t exp_retire [$];
    logic [XLEN-1:0] exp_resteer [$];
    ie_rec_t exp_ie [$];
    store_req_t exp_store [$];

    slot_t prog_q [$];
    bit took;
    logic [XLEN-1:0] next_eip;
    logic [XLEN-1:0] aw_q [$];
    logic [XLEN-1:0] w_q [$];
    int aw_wait, w_wait, b_owed;
    bit aw_done, w_done, full_seen;
    int issued, cycles, mismatches, failures;
    string test_name = "reset";

    wb_core_top u_dut (.*);

    always #20 clk = ~clk;

    task automatic check(string what, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            mismatches++;
            $display("mismatch in %s, %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(string msg);
        failures++;
        $display("error in %s: %s", test_name, msg);
    endtask

    task automatic alu_commit(retire_t r, logic [XLEN:0] sum);
        eflags_t f;
        f.zero  = (sum[XLEN-1:0] == '0);
        f.sign  = sum[XLEN-1];
        f.carry = sum[XLEN];  // borrow for SUB
        m_regs[r.dst] = sum[XLEN-1:0];
        m_flags = f;
        r.value = sum[XLEN-1:0];
        r.writes_reg = 1'b1;
        r.flags = f;
        exp_retire.push_back(r);
    endtask

    task automatic raise_ie(ie_e kind, logic [XLEN-1:0] eip);
        exp_ie.push_back('{kind: kind, eip: eip});
        m_squash = 1'b1;
    endtask

    // architectural effect of one accepted instruction, in program order
    task automatic model_accept(instr_t i, logic [XLEN-1:0] eip);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] addr;
        retire_t r;
        if (m_squash || m_halted) return;
        a = m_regs[i.src1];
        b = m_regs[i.src2];
        r = '{eip: eip, dst: i.dst, value: '0, writes_reg: 1'b0, flags: m_flags};
        case (i.opcode)
            ADD: alu_commit(r, {1'b0, a} + {1'b0, b});
            SUB: alu_commit(r, {1'b0, a} - {1'b0, b});
            AND: alu_commit(r, {1'b0, a & b});
            OR:  alu_commit(r, {1'b0, a | b});
            XOR: alu_commit(r, {1'b0, a ^ b});
            MOVI: begin
                m_regs[i.dst] = {16'h0, i.imm};  // flags untouched
                r.value = {16'h0, i.imm};
                r.writes_reg = 1'b1;
                exp_retire.push_back(r);
            end
            STORE: begin
                addr = a + {{16{i.imm[15]}}, i.imm};
                if (addr[1:0] != 2'b00) begin
                    raise_ie(IE_MISALIGNED, eip);
                end else begin
                    exp_store.push_back('{addr: addr, data: b});
                    exp_retire.push_back(r);
                end
            end
            JMP, JZ: begin
                exp_retire.push_back(r);
                if (i.opcode == JMP || m_flags.zero) begin
                    exp_resteer.push_back({16'h0, i.imm});
                    m_squash = 1'b1;
                end
            end
            HALT: begin
                exp_retire.push_back(r);
                m_halted = 1'b1;
            end
            NOP: exp_retire.push_back(r);
            default: raise_ie(IE_ILLEGAL, eip);
        endcase
    endtask

    task automatic drive_slave();
        if (aw_done) begin
            awready = 1'b0;
            aw_done = 0;
            aw_wait = $urandom_range(3, 0);
        end
        if (w_done) begin
            wready = 1'b0;
            w_done = 0;
            w_wait = $urandom_range(3, 0);
        end
        if (awvalid && !awready) begin
            if (aw_wait == 0) awready = 1'b1;
            else aw_wait--;
        end
        if (wvalid && !wready) begin
            if (w_wait == 0) wready = 1'b1;
            else w_wait--;
        end
        bvalid = (b_owed > 0);
    endtask

    task automatic match_store();
        store_req_t e;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
        addr = aw_q.pop_front();
        data = w_q.pop_front();
        b_owed++;
        if (exp_store.size() == 0) begin
            report_failure($sformatf("AXI write to %h that no store asked for", addr));
        end else begin
            e = exp_store.pop_front();
            check("store address", e.addr, addr);
            check("store data", e.data, data);
        end
    endtask

    task automatic check_retire();
        retire_t e;
        if (exp_retire.size() == 0) begin
            report_failure($sformatf("instruction at %h retired but should not", retire.eip));
        end else begin
            e = exp_retire.pop_front();
            check("retire eip", e.eip, retire.eip);
            check("retire writes_reg", e.writes_reg, retire.writes_reg);
            if (e.writes_reg) begin
                check("retire dst", e.dst, retire.dst);
                check("retire value", e.value, retire.value);
            end
            check("retire flags", e.flags, retire.flags);
        end
    endtask

    // inputs change 2 ns after the rising edge
    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (took) begin
                void'(prog_q.pop_front());
                took = 0;
            end
            in_valid = (prog_q.size() != 0);
            if (in_valid) begin
                in_instr = prog_q[0].instr;
                in_eip   = prog_q[0].eip;
            end
            drive_slave();
        end
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (arst_n) begin
            if (in_valid && in_ready) begin
                model_accept(prog_q[0].instr, prog_q[0].eip);
                took = 1;
            end
            if (retire_valid) check_retire();
            if (resteer) begin
                if (exp_resteer.size() == 0) report_failure("resteer with no taken branch");
                else check("new_eip", exp_resteer.pop_front(), new_eip);
            end
            if (ie_val) begin
                if (exp_ie.size() == 0) begin
                    report_failure("exception pulse with no faulting instruction");
                end else begin
                    check("ie_type", exp_ie[0].kind, ie_type);
                    check("ie_eip", exp_ie[0].eip, ie_eip);
                    void'(exp_ie.pop_front());
                end
            end
            if (resteer || ie_val) m_squash = 0;  // same-cycle transfer already dropped above
            if (awvalid && awready) begin
                aw_q.push_back(awaddr);
                aw_done = 1;
            end
            if (wvalid && wready) begin
                check("wstrb", {(XLEN/8){1'b1}}, wstrb);
                w_q.push_back(wdata);
                w_done = 1;
            end
            while (aw_q.size() != 0 && w_q.size() != 0) match_store();
            if (bvalid && bready) b_owed--;
            if (u_dut.store_full) full_seen = 1;
        end
    end

    always @(negedge clk) begin
        cycles++;
        if (cycles > 30 * issued + 200) begin
            $display("timeout: run hung with %0d retires and %0d resteers pending",
                     exp_retire.size(), exp_resteer.size());
            $display("timeout: %0d exceptions and %0d stores still pending",
                     exp_ie.size(), exp_store.size());
            $display("errors: %0d mismatches, %0d other failures", mismatches,
                     failures + u_dut.u_asserts.assert_errors + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic instr_t encode(logic [3:0] op, int dst, int s1, int s2, logic [15:0] imm);
        encode = '{opcode: op, dst: REG_AW'(dst), src1: REG_AW'(s1), src2: REG_AW'(s2),
                   unused: 3'b000, imm: imm};
    endfunction

    task automatic send(logic [3:0] op, int dst, int s1, int s2, logic [15:0] imm);
        prog_q.push_back('{instr: encode(op, dst, s1, s2, imm), eip: next_eip});
        next_eip += 4;
        issued++;
    endtask

    task automatic jump_to(logic [XLEN-1:0] eip);
        next_eip = eip;
    endtask

    // wait until every expected event has shown up and the bus is quiet
    task automatic drain();
        int quiet;
        quiet = 0;
        while (quiet < 5) begin
            @(posedge clk);
            if (prog_q.size() == 0 && exp_retire.size() == 0 && exp_resteer.size() == 0 &&
                exp_ie.size() == 0 && exp_store.size() == 0 && b_owed == 0) quiet++;
            else quiet = 0;
        end
    endtask

    task automatic alu_ops();
        test_name = "alu_ops";
        send(MOVI, 1, 0, 0, 16'h8000);
        send(MOVI, 2, 0, 0, 16'h7fff);
        send(ADD, 3, 1, 2, 16'h0);
        send(SUB, 4, 2, 1, 16'h0);  // negative with borrow
        send(AND, 5, 1, 2, 16'h0);  // zero
        send(OR, 6, 1, 2, 16'h0);
        send(XOR, 7, 3, 6, 16'h0);
        send(ADD, 0, 4, 4, 16'h0);  // carry out
        send(MOVI, 7, 0, 0, 16'h0001);
        send(NOP, 0, 0, 0, 16'h0);
        drain();
    endtask

    task automatic dependent_chain();
        test_name = "dependent_chain";
        send(MOVI, 1, 0, 0, 16'($urandom));
        send(MOVI, 2, 0, 0, 16'($urandom));
        repeat (4) begin
            send(ADD, 3, 1, 2, 16'h0);
            send(XOR, 1, 3, 2, 16'h0);
            send(SUB, 2, 1, 3, 16'h0);
        end
        drain();
    endtask

    task automatic store_stream();
        test_name = "store_stream";
        full_seen = 0;
        send(MOVI, 1, 0, 0, 16'h1000);
        send(MOVI, 2, 0, 0, 16'ha5a5);
        send(MOVI, 3, 0, 0, 16'h0f0f);
        for (int k = 0; k < 8; k++) begin
            send(STORE, 0, 1, (k % 2) ? 3 : 2, 16'(k * 4));
        end
        send(STORE, 0, 1, 2, 16'hfffc);  // negative offset
        send(ADD, 4, 2, 3, 16'h0);
        drain();
        if (!full_seen) report_failure("store queue never filled under AXI back-pressure");
    endtask

    task automatic branches();
        test_name = "branches";
        jump_to(32'h100);
        send(JMP, 0, 0, 0, 16'h0200);
        send(MOVI, 5, 0, 0, 16'hdead);
        send(MOVI, 6, 0, 0, 16'hdead);
        send(MOVI, 7, 0, 0, 16'hdead);
        drain();
        jump_to(32'h200);
        send(SUB, 3, 1, 1, 16'h0);  // zero flag set
        send(JZ, 0, 0, 0, 16'h0300);
        send(MOVI, 5, 0, 0, 16'hbeef);
        send(MOVI, 7, 0, 0, 16'hbeef);
        drain();
        jump_to(32'h300);
        send(ADD, 4, 1, 2, 16'h0);
        send(JZ, 0, 0, 0, 16'h0400);  // not taken
        send(ADD, 6, 5, 7, 16'h0);
        drain();
    endtask

    task automatic exceptions();
        test_name = "exceptions";
        jump_to(32'h500);
        send(4'hc, 1, 0, 0, 16'h0);  // undefined opcode
        send(MOVI, 1, 0, 0, 16'hdead);
        send(MOVI, 2, 0, 0, 16'hbeef);
        drain();
        send(MOVI, 3, 0, 0, 16'h2000);
        send(STORE, 0, 3, 2, 16'h0002);
        send(MOVI, 4, 0, 0, 16'hdead);
        drain();
        send(ADD, 5, 1, 4, 16'h0);
        send(ADD, 6, 2, 2, 16'h0);
        drain();
    endtask

    task automatic halt_stop();
        test_name = "halt_stop";
        send(HALT, 0, 0, 0, 16'h0);
        send(MOVI, 1, 0, 0, 16'h0bad);
        send(MOVI, 2, 0, 0, 16'h0bad);
        while (!halted) @(negedge clk);
        repeat (10) begin
            @(negedge clk);
            if (in_ready) report_failure("in_ready high after halt");
            if (!halted) report_failure("halted dropped before reset");
        end
        if (exp_retire.size() != 0) report_failure("HALT never retired");
        prog_q.delete();
        took = 0;
    endtask

    initial begin
        void'($urandom(96382));
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        in_eip   = '0;
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        next_eip = '0;
        m_flags  = '0;
        for (int r = 0; r < NUM_REGS; r++) m_regs[r] = '0;
        aw_wait = $urandom_range(3, 0);
        w_wait  = $urandom_range(3, 0);
        repeat (2) @(posedge clk);
        #2 arst_n = 1'b1;
        alu_ops();
        dependent_chain();
        store_stream();
        branches();
        exceptions();
        halt_stop();
        failures += u_dut.u_asserts.assert_errors;  // bound property failures
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
store_axil_master.sv
wb_core_top.sv
wb_core_asserts.sv
tb_wb_core.sv

// File: Bender.yml
package:
  name: wb_core

sources:
  - files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - reg_file.sv
      - decode_stage.sv
      - execute_stage.sv
      - writeback_stage.sv
      - store_axil_master.sv
      - wb_core_top.sv
  - target: simulation
    files:
      - wb_core_asserts.sv
      - tb_wb_core.sv
